// File: Makefile
# Verilator build for the RV32I datapath
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= tb_rv_datapath
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_EXE   ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+src
src/rv_pkg.sv
src/function_unit.sv
src/reg_file.sv
src/data_mem.sv
src/exec_datapath.sv
src/rv_datapath_top.sv
sim/tb_clock_gen.sv
sim/tb_rv_datapath.sv

// File: sim/tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int half_period = 10,
    parameter int rst_cycles  = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // active low, released on a rising edge
    initial begin
        rst = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// File: sim/tb_rv_datapath.sv
// RV32I datapath testbench

`timescale 1ns/10ps

`include "rv_macros.svh"

module tb_rv_datapath;

    import rv_pkg::*;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    issue_t              issue;
    logic [`RV_XLEN-1:0] r_for_pc;
    logic                wb_valid;
    wb_t                 wb;
    logic                br_valid;
    logic                br_taken;

    // reference state
    logic [31:0] model_regs [`RV_NREGS];
    logic [7:0]  model_mem [4*`RV_DMEM_WORDS];
    logic [31:0] lfsr;
    int          errors;
    int          problems;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    rv_datapath_top rv_datapath_top_i (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue),
        .r_for_pc(r_for_pc), .wb_valid(wb_valid), .wb(wb),
        .br_valid(br_valid), .br_taken(br_taken)
    );

    // fibonacci lfsr on taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // fn is {fun7, fun3}
    function automatic logic [31:0] alu_model(input logic [3:0] fn, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (fn[2:0])
            3'd0: r = fn[3] ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (fn[3]) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // f3 bit 2 asks for zero extension
    function automatic logic [31:0] load_model(input logic [2:0] f3, input int a);
        logic [31:0] r;
        case (f3[1:0])
            2'd0: r = {{24{~f3[2] & model_mem[a][7]}}, model_mem[a]};
            2'd1: r = {{16{~f3[2] & model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
            default: r = {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
        endcase
        return r;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        errors++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_failure(input string msg);
        problems++;
        $display("%s", msg);
    endtask

    // one issue cycle with the rs1 port checked mid cycle
    task automatic drive_issue(input string name, input inst_type_e t, input logic [3:0] fn,
                               input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [31:0] pc,
                               input logic [31:0] imm);
        issue_t req;
        req.cword.rs2   = rs2;
        req.cword.rs1   = rs1;
        req.cword.rd    = rd;
        req.cword.fn    = fn;
        req.cword.itype = t;
        req.pc          = pc;
        req.imm         = imm;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue       <= req;
        @(negedge clk);
        if (r_for_pc !== model_regs[rs1]) begin
            flag_mismatch({name, " r_for_pc"}, model_regs[rs1], r_for_pc);
        end
    endtask

    task automatic release_issue();
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    // the strobe is due in the third cycle after the issue cycle
    task automatic wait_strobe(input string name, output logic got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < 10) begin
            @(negedge clk);
            n++;
            if (wb_valid || br_valid) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            report_failure($sformatf("timeout waiting for a result strobe in %s", name));
        end else if (n != 3) begin
            report_failure($sformatf("%s strobed %0d cycles after issue instead of 3", name, n));
        end
    endtask

    task automatic writeback_op(input string name, input inst_type_e t, input logic [3:0] fn,
                                input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [4:0] rs2, input logic [31:0] pc,
                                input logic [31:0] imm, input logic [31:0] exp_data);
        logic got;
        drive_issue(name, t, fn, rd, rs1, rs2, pc, imm);
        release_issue();
        wait_strobe(name, got);
        if (got) begin
            if (!wb_valid) begin
                report_failure($sformatf("%s gave a branch strobe and no writeback", name));
            end
            if (wb.rd !== rd) begin
                flag_mismatch({name, " rd"}, {27'd0, rd}, {27'd0, wb.rd});
            end
            if (wb.data !== exp_data) begin
                flag_mismatch(name, exp_data, wb.data);
            end
            @(negedge clk);
            if (wb_valid) begin
                report_failure($sformatf("%s held wb_valid longer than one cycle", name));
            end
        end
        if (rd != 5'd0) begin
            model_regs[rd] = exp_data;
        end
    endtask

    task automatic branch_op(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        string name;
        logic  exp_taken;
        logic  got;
        name = $sformatf("branch f3=%0d a=%h b=%h", f3, model_regs[rs1], model_regs[rs2]);
        exp_taken = branch_model(f3, model_regs[rs1], model_regs[rs2]);
        drive_issue(name, IT_BRANCH, {1'b0, f3}, 5'd0, rs1, rs2, 32'd0, 32'd0);
        release_issue();
        wait_strobe(name, got);
        if (got && wb_valid) begin
            report_failure($sformatf("%s raised wb_valid", name));
        end else if (got && (br_taken !== exp_taken)) begin
            flag_mismatch(name, {31'd0, exp_taken}, {31'd0, br_taken});
        end
    endtask

    // a store gives no strobe and its write lands three cycles after issue
    task automatic store_op(input logic [2:0] f3, input logic [4:0] base, input logic [4:0] src,
                            input logic [31:0] imm);
        string name;
        int    addr;
        int    nbytes;
        name   = $sformatf("store f3=%0d imm=%0d", f3, imm);
        addr   = int'((model_regs[base] + imm) & (4 * `RV_DMEM_WORDS - 1));
        nbytes = 1 << f3[1:0];
        drive_issue(name, IT_STORE, {1'b0, f3}, 5'd0, base, src, 32'd0, imm);
        release_issue();
        repeat (4) begin
            @(negedge clk);
            if (wb_valid || br_valid) begin
                report_failure($sformatf("%s raised a result strobe", name));
            end
        end
        for (int k = 0; k < nbytes; k++) begin
            model_mem[addr + k] = model_regs[src][8*k +: 8];
        end
    endtask

    task automatic load_op(input logic [2:0] f3, input logic [4:0] base, input logic [31:0] imm);
        int addr;
        addr = int'((model_regs[base] + imm) & (4 * `RV_DMEM_WORDS - 1));
        writeback_op($sformatf("load f3=%0d addr=%0h", f3, addr), IT_LOAD, {1'b0, f3}, 5'd12,
                     base, 5'd0, 32'd0, imm, load_model(f3, addr));
    endtask

    // lui of the rounded upper part followed by addi of the signed rest
    task automatic set_register(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) & 32'hffff_f000;
        writeback_op("lui", IT_LUI, 4'h0, rd, 5'd0, 5'd0, 32'd0, hi, hi);
        writeback_op("addi", IT_IMM, 4'h0, rd, rd, 5'd0, 32'd0, value - hi, value);
    endtask

    task automatic reset_state();
        repeat (4) begin
            @(negedge clk);
            if (wb_valid || br_valid) begin
                report_failure("a result strobe appeared after reset with nothing issued");
            end
        end
        writeback_op("reset add", IT_REG, 4'h0, 5'd3, 5'd1, 5'd2, 32'd0, 32'd0, 32'd0);
    endtask

    task automatic reg_alu_ops();
        logic [3:0] fns [10];
        fns = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        for (int round = 0; round < 3; round++) begin
            set_register(5'd1, lfsr_bits(32));
            set_register(5'd2, lfsr_bits(32));
            for (int i = 0; i < 10; i++) begin
                writeback_op($sformatf("reg fn=%h", fns[i]), IT_REG, fns[i], 5'(10 + i),
                             5'd1, 5'd2, 32'd0, 32'd0,
                             alu_model(fns[i], model_regs[1], model_regs[2]));
            end
        end
    endtask

    task automatic upper_and_links();
        logic [3:0]  fns [9];
        logic [31:0] imm;
        logic [31:0] up;
        logic [31:0] pc;
        fns = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};
        set_register(5'd1, lfsr_bits(32));
        for (int i = 0; i < 9; i++) begin
            // shift amount for shifts and a sign-extended 12 bits otherwise
            if (fns[i][1:0] == 2'b01) begin
                imm = lfsr_bits(5);
            end else begin
                imm = lfsr_bits(12);
                imm = {{20{imm[11]}}, imm[11:0]};
            end
            writeback_op($sformatf("imm fn=%h", fns[i]), IT_IMM, fns[i], 5'(20 + i), 5'd1,
                         5'd0, 32'd0, imm, alu_model(fns[i], model_regs[1], imm));
        end
        up = lfsr_bits(20) << 12;
        pc = lfsr_bits(30) << 2;
        writeback_op("lui", IT_LUI, 4'h0, 5'd4, 5'd0, 5'd0, 32'd0, up, up);
        writeback_op("auipc", IT_AUIPC, 4'h0, 5'd5, 5'd0, 5'd0, pc, up, pc + up);
        writeback_op("jal", IT_JAL, 4'h0, 5'd6, 5'd0, 5'd0, pc, lfsr_bits(12) << 1, pc + 32'd4);
        writeback_op("jalr", IT_JALR, 4'h0, 5'd7, 5'd1, 5'd0, pc + 32'd8, 32'd0, pc + 32'd12);
    endtask

    task automatic store_load();
        set_register(5'd8, 32'h100);
        set_register(5'd9, lfsr_bits(32));
        store_op(3'd2, 5'd8, 5'd9, 32'd0);
        for (int off = 0; off < 4; off += 2) begin
            set_register(5'd9, lfsr_bits(32));
            store_op(3'd1, 5'd8, 5'd9, 32'(4 + off));
        end
        for (int off = 0; off < 4; off++) begin
            set_register(5'd9, lfsr_bits(32));
            store_op(3'd0, 5'd8, 5'd9, 32'(8 + off));
        end
        // every load kind at every legal offset
        for (int w = 0; w < 3; w++) begin
            load_op(3'd2, 5'd8, 32'(4 * w));
            for (int off = 0; off < 4; off += 2) begin
                load_op(3'd1, 5'd8, 32'(4 * w + off));
                load_op(3'd5, 5'd8, 32'(4 * w + off));
            end
            for (int off = 0; off < 4; off++) begin
                load_op(3'd0, 5'd8, 32'(4 * w + off));
                load_op(3'd4, 5'd8, 32'(4 * w + off));
            end
        end
        set_register(5'd8, 32'h10c);
        load_op(3'd2, 5'd8, -32'd12);
    endtask

    task automatic branch_conditions();
        logic [31:0] lhs [6];
        logic [31:0] rhs [6];
        logic [31:0] pos;
        logic [31:0] neg;
        pos = lfsr_bits(30);
        neg = 32'h8000_0000 | lfsr_bits(31);
        lhs = '{pos, pos, pos + 32'd1, neg, pos, 32'h7fff_ffff};
        rhs = '{pos, pos + 32'd1, pos, pos, neg, 32'h8000_0001};
        for (int p = 0; p < 6; p++) begin
            set_register(5'd1, lhs[p]);
            set_register(5'd2, rhs[p]);
            for (int f = 0; f < 8; f++) begin
                if (f != 2 && f != 3) begin
                    branch_op(3'(f), 5'd1, 5'd2);
                end
            end
        end
    endtask

    task automatic x0_and_overlap();
        logic [4:0]  rds [3];
        logic [31:0] vals [3];
        int          got;
        int          n;
        writeback_op("write x0", IT_IMM, 4'h0, 5'd0, 5'd1, 5'd0, 32'd0, 32'd5,
                     model_regs[1] + 32'd5);
        writeback_op("read x0", IT_REG, 4'h0, 5'd13, 5'd0, 5'd0, 32'd0, 32'd0, 32'd0);
        rds     = '{5'd14, 5'd15, 5'd16};
        vals[0] = model_regs[1] + model_regs[2];
        vals[1] = model_regs[1] ^ model_regs[2];
        vals[2] = lfsr_bits(20) << 12;
        drive_issue("overlap add", IT_REG, 4'h0, rds[0], 5'd1, 5'd2, 32'd0, 32'd0);
        drive_issue("overlap xor", IT_REG, 4'h4, rds[1], 5'd1, 5'd2, 32'd0, 32'd0);
        drive_issue("overlap lui", IT_LUI, 4'h0, rds[2], 5'd0, 5'd0, 32'd0, vals[2]);
        release_issue();
        got = 0;
        n   = 0;
        while (got < 3 && n < 12) begin
            @(negedge clk);
            n++;
            if (wb_valid) begin
                if (wb.rd !== rds[got]) begin
                    flag_mismatch("overlap rd", {27'd0, rds[got]}, {27'd0, wb.rd});
                end
                if (wb.data !== vals[got]) begin
                    flag_mismatch("overlap data", vals[got], wb.data);
                end
                got++;
            end
        end
        if (got < 3) begin
            report_failure("timeout waiting for three back-to-back writebacks");
        end
        for (int i = 0; i < 3; i++) begin
            model_regs[rds[i]] = vals[i];
        end
    endtask

    initial begin
        int n;
        issue_valid = 1'b0;
        issue       = '0;
        lfsr        = 32'h229b_0906;
        errors      = 0;
        problems    = 0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        n = 0;
        while (rst !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b1) begin
            report_failure("reset was never released");
        end
        reset_state();
        reg_alu_ops();
        upper_and_links();
        store_load();
        branch_conditions();
        x0_and_overlap();
        repeat (2) @(posedge clk);
        $display("error count: %0d mismatches, %0d other failures", errors, problems);
        if (errors == 0 && problems == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src/data_mem.sv
// Byte-strobed data memory

`timescale 1ns/10ps

`include "rv_macros.svh"

module data_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  logic [`RV_DMEM_AW-1:0] addr,
    input  logic [`RV_XLEN-1:0]    wdata,
    input  rv_pkg::mem_fn_t        fn,
    input  logic [1:0]             offset,
    output logic [`RV_XLEN-1:0]    rdata
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [3:0]          mask;
    logic [`RV_XLEN-1:0] wdata_rep;
    logic [`RV_XLEN-1:0] rd_word;
    mem_fn_t             rd_fn;
    logic [1:0]          rd_off;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;

    // byte lanes and replicated store data
    always_comb begin
        case (fn.size)
            SZ_BYTE: begin
                mask      = 4'b0001 << offset;
                wdata_rep = {4{wdata[7:0]}};
            end
            SZ_HALF: begin
                mask      = offset[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{wdata[15:0]}};
            end
            default: begin
                mask      = 4'b1111;
                wdata_rep = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    mem[addr][8*i +: 8] <= wdata_rep[8*i +: 8];
                end
            end
        end
        rd_word <= mem[addr];
    end

    // access shape follows the word into the next cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_fn  <= '0;
            rd_off <= '0;
        end else begin
            rd_fn  <= fn;
            rd_off <= offset;
        end
    end

    // load extraction
    assign rd_byte = rd_word[8*rd_off +: 8];
    assign rd_half = rd_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (rd_fn.size)
            SZ_BYTE: rdata = {{(`RV_XLEN-8){~rd_fn.zero_ext & rd_byte[7]}}, rd_byte};
            SZ_HALF: rdata = {{(`RV_XLEN-16){~rd_fn.zero_ext & rd_half[15]}}, rd_half};
            default: rdata = rd_word;
        endcase
    end

    half_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        (fn.size == SZ_HALF) |-> !offset[0]
    );

endmodule

// File: src/exec_datapath.sv
// RV32I execution datapath sequencing

`timescale 1ns/10ps

`include "rv_macros.svh"

module exec_datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  rv_pkg::issue_t         issue,
    output logic [`RV_REG_AW-1:0]  rs1_addr,
    output logic [`RV_REG_AW-1:0]  rs2_addr,
    input  logic [`RV_XLEN-1:0]    rs1_val,
    input  logic [`RV_XLEN-1:0]    rs2_val,
    output logic [`RV_XLEN-1:0]    fu_a,
    output logic [`RV_XLEN-1:0]    fu_b,
    output rv_pkg::alu_fn_t        fu_fn,
    input  logic [`RV_XLEN-1:0]    fu_s,
    input  rv_pkg::flags_t         fu_flags,
    output logic                   mem_we,
    output logic [`RV_DMEM_AW-1:0] mem_addr,
    output logic [`RV_XLEN-1:0]    mem_wdata,
    output rv_pkg::mem_fn_t        mem_fn,
    output logic [1:0]             mem_offset,
    input  logic [`RV_XLEN-1:0]    mem_rdata,
    output logic                   wb_valid,
    output rv_pkg::wb_t            wb,
    output logic                   br_valid,
    output logic                   br_taken
);

    import rv_pkg::*;

    cword_t              cw;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    alu_fn_t             op_fn;

    // stage 1, operands captured
    logic                s1_valid;
    cword_t              s1_cw;
    logic [`RV_XLEN-1:0] s1_imm;
    logic [`RV_XLEN-1:0] s1_store;

    // stage 2, result and flags
    logic                s2_valid;
    inst_type_e          s2_type;
    logic [2:0]          s2_fun3;
    flags_t              s2_flags;
    wb_t                 s2_wb;
    logic                cond;

    // stage 3, strobes
    logic                s3_valid;
    inst_type_e          s3_type;
    wb_t                 s3_wb;
    logic                s3_taken;

    assign cw       = issue.cword;
    assign rs1_addr = cw.rs1;
    assign rs2_addr = cw.rs2;

    always_comb begin
        case (cw.itype)
            IT_JAL, IT_JALR, IT_AUIPC: op_a = issue.pc;
            default:                   op_a = rs1_val;
        endcase
        case (cw.itype)
            IT_REG, IT_BRANCH: op_b = rs2_val;
            IT_JAL, IT_JALR:   op_b = `RV_XLEN'd4;
            default:           op_b = issue.imm;
        endcase
        // address, link and upper-immediate math is a plain add
        case (cw.itype)
            IT_LOAD, IT_STORE, IT_LUI, IT_AUIPC, IT_JAL, IT_JALR:
                op_fn = '{fun7: 1'b0, fun3: 3'b000};
            IT_BRANCH:
                op_fn = '{fun7: 1'b1, fun3: 3'b000};
            default:
                op_fn = cw.fn.alu;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            mem_we   <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            mem_we   <= s1_valid && (s1_cw.itype == IT_STORE);
        end
    end

    always_ff @(posedge clk) begin
        s1_cw    <= cw;
        s1_imm   <= issue.imm;
        s1_store <= rs2_val;
        fu_a     <= op_a;
        fu_b     <= op_b;
        fu_fn    <= op_fn;
    end

    always_ff @(posedge clk) begin
        s2_type     <= s1_cw.itype;
        s2_fun3     <= s1_cw.fn.alu.fun3;
        s2_flags    <= fu_flags;
        s2_wb.rd    <= s1_cw.rd;
        s2_wb.data  <= (s1_cw.itype == IT_LUI) ? s1_imm : fu_s;
        mem_addr    <= fu_s[`RV_DMEM_AW+1:2];
        mem_offset  <= fu_s[1:0];
        mem_wdata   <= s1_store;
        // non-memory ops present a byte access, no alignment rule applies
        if ((s1_cw.itype == IT_LOAD) || (s1_cw.itype == IT_STORE)) begin
            mem_fn <= s1_cw.fn.mem;
        end else begin
            mem_fn <= '0;
        end
    end

    // branch condition from the subtract flags
    always_comb begin
        case (s2_fun3)
            3'b000:  cond = s2_flags.z;
            3'b001:  cond = ~s2_flags.z;
            3'b100:  cond = s2_flags.n ^ s2_flags.v;
            3'b101:  cond = ~(s2_flags.n ^ s2_flags.v);
            3'b110:  cond = ~s2_flags.c;
            3'b111:  cond = s2_flags.c;
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        s3_type  <= s2_type;
        s3_wb    <= s2_wb;
        s3_taken <= cond;
    end

    assign wb_valid = s3_valid && (s3_type != IT_STORE) && (s3_type != IT_BRANCH);
    assign wb.rd    = s3_wb.rd;
    assign wb.data  = (s3_type == IT_LOAD) ? mem_rdata : s3_wb.data;
    assign br_valid = s3_valid && (s3_type == IT_BRANCH);
    assign br_taken = s3_taken;

    itype_legal: assert property (
        @(posedge clk) disable iff (!rst)
        issue_valid |-> (issue.cword.itype <= IT_JAL)
    );

endmodule

// File: src/function_unit.sv
// RV32I arithmetic and logic unit

`timescale 1ns/10ps

`include "rv_macros.svh"

module function_unit (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_fn_t     fn,
    output logic [`RV_XLEN-1:0] s,
    output rv_pkg::flags_t      flags
);

    logic                use_sub;
    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN:0]   sum;
    logic                lt_signed;

    // compares always subtract so the flags are meaningful
    assign use_sub = fn.fun7 || (fn.fun3 == 3'b010) || (fn.fun3 == 3'b011);
    assign b_eff   = use_sub ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, use_sub};

    // carry set means no borrow on subtraction
    assign flags.z = (sum[`RV_XLEN-1:0] == '0);
    assign flags.c = sum[`RV_XLEN];
    assign flags.n = sum[`RV_XLEN-1];
    assign flags.v = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &&
                     (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);

    assign lt_signed = flags.n ^ flags.v;

    always_comb begin
        case (fn.fun3)
            // add / sub
            3'b000: s = sum[`RV_XLEN-1:0];
            3'b001: s = a << b[4:0];
            // slt
            3'b010: s = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            // sltu, borrow out
            3'b011: s = {{(`RV_XLEN-1){1'b0}}, ~sum[`RV_XLEN]};
            3'b100: s = a ^ b;
            3'b101: begin
                if (fn.fun7) begin
                    s = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    s = a >> b[4:0];
                end
            end
            3'b110: s = a | b;
            default: s = a & b;
        endcase
    end

endmodule

// File: src/reg_file.sv
// RV32I register file

`timescale 1ns/10ps

`include "rv_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rd_addr0,
    input  logic [`RV_REG_AW-1:0] rd_addr1,
    input  logic                  we,
    input  rv_pkg::wb_t           wr,
    output logic [`RV_XLEN-1:0]   rd_dout0,
    output logic [`RV_XLEN-1:0]   rd_dout1
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is never written
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rd_dout0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    assign rd_dout1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

    // writeback target comes from the datapath stage 3 registers
    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst)
        we |-> !$isunknown(wr.rd)
    );

endmodule

// File: src/rv_datapath_top.sv
// RV32I datapath top level

`timescale 1ns/10ps

`include "rv_macros.svh"

module rv_datapath_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  rv_pkg::issue_t      issue,
    output logic [`RV_XLEN-1:0] r_for_pc,
    output logic                wb_valid,
    output rv_pkg::wb_t         wb,
    output logic                br_valid,
    output logic                br_taken
);

    import rv_pkg::*;

    logic [`RV_REG_AW-1:0]  rs1_addr;
    logic [`RV_REG_AW-1:0]  rs2_addr;
    logic [`RV_XLEN-1:0]    rs2_val;
    logic [`RV_XLEN-1:0]    fu_a;
    logic [`RV_XLEN-1:0]    fu_b;
    logic [`RV_XLEN-1:0]    fu_s;
    alu_fn_t                fu_fn;
    flags_t                 fu_flags;
    logic                   mem_we;
    logic [`RV_DMEM_AW-1:0] mem_addr;
    logic [`RV_XLEN-1:0]    mem_wdata;
    mem_fn_t                mem_fn;
    logic [1:0]             mem_offset;
    logic [`RV_XLEN-1:0]    mem_rdata;

    exec_datapath u_exec (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(r_for_pc), .rs2_val(rs2_val),
        .fu_a(fu_a), .fu_b(fu_b), .fu_fn(fu_fn), .fu_s(fu_s), .fu_flags(fu_flags),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_fn(mem_fn),
        .mem_offset(mem_offset), .mem_rdata(mem_rdata),
        .wb_valid(wb_valid), .wb(wb), .br_valid(br_valid), .br_taken(br_taken)
    );

    function_unit u_fu (.a(fu_a), .b(fu_b), .fn(fu_fn), .s(fu_s), .flags(fu_flags));

    // rs1 read port doubles as the jalr base output
    reg_file u_rf (
        .clk(clk), .rst(rst), .rd_addr0(rs1_addr), .rd_addr1(rs2_addr),
        .we(wb_valid), .wr(wb), .rd_dout0(r_for_pc), .rd_dout1(rs2_val)
    );

    data_mem u_dmem (
        .clk(clk), .rst(rst), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
        .fn(mem_fn), .offset(mem_offset), .rdata(mem_rdata)
    );

endmodule

// File: src/rv_macros.svh
// RV32I datapath widths and depths

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width
`define RV_XLEN 32

// register file
`define RV_NREGS 32
`define RV_REG_AW 5

// data memory, word organized
`define RV_DMEM_WORDS 128
`define RV_DMEM_AW 7

`endif

// File: src/rv_pkg.sv
// RV32I datapath types

`include "rv_macros.svh"

package rv_pkg;

    // instruction class as issued by the control unit
    typedef enum logic [3:0] {
        IT_LOAD   = 4'd0,
        IT_IMM    = 4'd1,
        IT_STORE  = 4'd2,
        IT_REG    = 4'd3,
        IT_LUI    = 4'd4,
        IT_AUIPC  = 4'd5,
        IT_BRANCH = 4'd6,
        IT_JALR   = 4'd7,
        IT_JAL    = 4'd8
    } inst_type_e;

    // fun7 is only the sub/sra modifier bit
    typedef struct packed {
        logic       fun7;
        logic [2:0] fun3;
    } alu_fn_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    // same bit positions as the load/store fun3
    typedef struct packed {
        logic      spare;
        logic      zero_ext;
        mem_size_e size;
    } mem_fn_t;

    typedef union packed {
        alu_fn_t alu;
        mem_fn_t mem;
    } fn_sel_u;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rd;
        fn_sel_u               fn;
        inst_type_e            itype;
    } cword_t;

    typedef struct packed {
        cword_t              cword;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] imm;
    } issue_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } wb_t;

endpackage
